/* rtl/zx_pkg.sv */
// Shared definitions for the Spectrum 128 host glue
// Z80 bus and RAM request structs, port data byte union
// Turbo rate and machine enums, memory map and clock-enable constants

`default_nettype none

package zx_pkg;

	// ========================================
	// Memory map
	// ========================================
	// RAM address is {spare, region, bank, offset}, region set for ROM
	localparam int RAM_ADDR_W = 19;
	localparam int RAM_OFS_W  = 14;

	localparam logic [2:0] ROM_BANK_BASE = 3'd0;
	localparam logic [2:0] SCREEN_BANK   = 3'd5;
	localparam logic [2:0] MID_BANK      = 3'd2;

	// ========================================
	// CPU clock enables
	// ========================================
	// Periods in clk_sys cycles
	localparam int CE_PERIOD_3M5 = 8;
	localparam int CE_PERIOD_7M  = 4;
	localparam int CE_PERIOD_14M = 2;
	localparam int CE_CNT_W      = $clog2(CE_PERIOD_3M5);

	// Periods without enables after a rate change
	localparam int SETTLE_W = 2;
	localparam logic [SETTLE_W-1:0] TURBO_SETTLE = 2'd2;

	// ========================================
	// Types
	// ========================================
	typedef enum logic [1:0] {
		TURBO_3M5 = 2'd0,
		TURBO_7M  = 2'd1,
		TURBO_14M = 2'd2
	} zx_turbo_e;

	typedef enum logic [0:0] {
		MACHINE_128K = 1'b0,
		MACHINE_48K  = 1'b1
	} zx_machine_e;

	// One cycle of Z80 bus state, control flags active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} zx_bus_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic                  rd;
		logic                  we;
	} zx_ram_req_t;

	// CPU data byte as seen by port 0x7FFD or by the ULA port
	typedef union packed {
		struct packed {
			logic [1:0] spare;
			logic       lock;
			logic       rom_sel;
			logic       scr_sel;
			logic [2:0] bank;
		} page_view;
		struct packed {
			logic [2:0] unused;
			logic       ear;
			logic       mic;
			logic [2:0] border;
		} ula_view;
	} zx_io_byte_u;

endpackage

`default_nettype wire

/* rtl/zx_clock_enables.sv */
// CPU clock-enable generator
// Free-running divider, turbo rate switching with settle time, pause

`timescale 1ns/1ps
`default_nettype none

module zx_clock_enables (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire zx_pkg::zx_turbo_e turbo,
	input  wire                    pause,
	output logic                   cpu_ce_p,
	output logic                   cpu_ce_n
);

	logic [zx_pkg::CE_CNT_W-1:0] cnt;
	logic [zx_pkg::CE_CNT_W-1:0] mask;
	logic [zx_pkg::CE_CNT_W-1:0] half;
	logic [zx_pkg::SETTLE_W-1:0] settle;
	zx_pkg::zx_turbo_e           rate;
	logic                        p_hit;
	logic                        n_hit;
	logic                        run;

	// Period mask and half-period point of the applied rate
	always_comb begin
		case (rate)
			zx_pkg::TURBO_14M: begin
				mask = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_14M - 1);
				half = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_14M / 2);
			end
			zx_pkg::TURBO_7M: begin
				mask = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_7M - 1);
				half = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_7M / 2);
			end
			default: begin
				mask = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_3M5 - 1);
				half = zx_pkg::CE_CNT_W'(zx_pkg::CE_PERIOD_3M5 / 2);
			end
		endcase
	end

	assign p_hit = (cnt & mask) == '0;
	assign n_hit = (cnt & mask) == half;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt      <= '0;
			rate     <= turbo;
			settle   <= '0;
			run      <= 1'b0;
			cpu_ce_p <= 1'b0;
			cpu_ce_n <= 1'b0;
		end else begin
			cnt      <= cnt + 1'b1;
			cpu_ce_p <= p_hit & (settle == '0) & ~pause;
			// Falling edge follows the rising edge of the same period
			cpu_ce_n <= n_hit & run;

			// Period boundary
			if (p_hit) begin
				if (settle != '0) begin
					settle <= settle - 1'b1;
					run    <= 1'b0;
				end else begin
					run <= ~pause;
				end
			end

			// Rate switch only at the falling point
			if (n_hit && (turbo != rate)) begin
				rate   <= turbo;
				settle <= zx_pkg::TURBO_SETTLE;
				run    <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/zx_port_decoder.sv */
// I/O port decoder for 0x7FFD and the ULA port
// Registered write strobes with latched data byte, CPU read data mux

`timescale 1ns/1ps
`default_nettype none

module zx_port_decoder (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire zx_pkg::zx_bus_t bus,
	input  wire [7:0]            fe_read,
	input  wire [7:0]            ram_dout,
	output logic                 page_wr_stb,
	output logic                 ula_wr_stb,
	output zx_pkg::zx_io_byte_u  io_data,
	output logic [7:0]           cpu_din
);

	logic io_wr;
	logic io_wr_q;
	logic io_wr_rise;
	logic page_sel;
	logic ula_sel;
	logic mem_rd;
	logic ula_rd;

	// Interrupt acknowledge has m1 set and is not a port access
	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_rise = io_wr & ~io_wr_q;

	assign page_sel = ~bus.addr[15] & ~bus.addr[1];
	assign ula_sel  = ~bus.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q     <= 1'b0;
			page_wr_stb <= 1'b0;
			ula_wr_stb  <= 1'b0;
		end else begin
			io_wr_q     <= io_wr;
			page_wr_stb <= io_wr_rise & page_sel;
			ula_wr_stb  <= io_wr_rise & ula_sel;
		end
	end

	// Byte travels with its strobe
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			io_data <= bus.dout;
		end
	end

	// ========================================
	// Read data to the CPU
	// ========================================
	assign mem_rd = bus.mreq & bus.rd;
	assign ula_rd = bus.iorq & bus.rd & ~bus.m1 & ~bus.addr[0];

	always_comb begin
		if (mem_rd) begin
			cpu_din = ram_dout;
		end else if (ula_rd) begin
			cpu_din = fe_read;
		end else begin
			// Floating bus
			cpu_din = 8'hFF;
		end
	end

endmodule

`default_nettype wire

/* rtl/zx_paging.sv */
// 128K memory paging
// 0x7FFD page register with lock, 48K machine mode, RAM request mapping

`timescale 1ns/1ps
`default_nettype none

module zx_paging (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire zx_pkg::zx_machine_e machine,
	input  wire zx_pkg::zx_bus_t     bus,
	input  wire                      page_wr_stb,
	input  wire zx_pkg::zx_io_byte_u io_data,
	output zx_pkg::zx_ram_req_t      ram_req,
	output logic                     page_scr
);

	zx_pkg::zx_io_byte_u page_q;
	zx_pkg::zx_machine_e machine_q;
	logic                is_48k;
	logic                rom_sel;
	logic                rom_win;
	logic                region;
	logic [2:0]          bank;

	// ========================================
	// Page register
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_q    <= '0;
			machine_q <= machine;
		end else if (page_wr_stb && !page_q.page_view.lock && !is_48k) begin
			page_q <= io_data;
		end
	end

	assign is_48k   = machine_q == zx_pkg::MACHINE_48K;
	assign page_scr = page_q.page_view.scr_sel;

	// 48K machine always runs the BASIC ROM
	assign rom_sel = is_48k ? 1'b1 : page_q.page_view.rom_sel;

	// ========================================
	// Address mapping
	// ========================================
	always_comb begin
		region = 1'b0;
		case (bus.addr[15:14])
			2'd0: begin
				region = 1'b1;
				bank   = zx_pkg::ROM_BANK_BASE + {2'b00, rom_sel};
			end
			2'd1: begin
				bank = zx_pkg::SCREEN_BANK;
			end
			2'd2: begin
				bank = zx_pkg::MID_BANK;
			end
			default: begin
				bank = is_48k ? 3'd0 : page_q.page_view.bank;
			end
		endcase
	end

	assign rom_win = bus.addr[15:14] == 2'd0;

	always_comb begin
		ram_req.addr = {1'b0, region, bank, bus.addr[zx_pkg::RAM_OFS_W-1:0]};
		ram_req.rd   = bus.mreq & bus.rd;
		// ROM is read only
		ram_req.we   = bus.mreq & bus.wr & ~rom_win;
	end

endmodule

`default_nettype wire

/* rtl/zx_ula_port.sv */
// ULA port 0xFE
// Border, ear and mic output registers and the port read value

`timescale 1ns/1ps
`default_nettype none

module zx_ula_port (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      ula_wr_stb,
	input  wire zx_pkg::zx_io_byte_u io_data,
	input  wire [4:0]                key_data,
	input  wire                      ear_in,
	output logic [2:0]               border_color,
	output logic                     ear_out,
	output logic                     mic_out,
	output logic [7:0]               fe_read
);

	// Audio outputs start silent
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (ula_wr_stb) begin
			ear_out <= io_data.ula_view.ear;
			mic_out <= io_data.ula_view.mic;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ula_wr_stb) begin
			border_color <= io_data.ula_view.border;
		end
	end

	// Keys are active low, bits 7 and 5 read as 1
	assign fe_read = {1'b1, ear_in, 1'b1, key_data};

endmodule

`default_nettype wire

/* rtl/zx_host_top.sv */
// Spectrum 128 host glue top level
// Clock enables, port decoder, paging and ULA port

`timescale 1ns/1ps
`default_nettype none

module zx_host_top (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire zx_pkg::zx_bus_t     bus,
	input  wire zx_pkg::zx_turbo_e   turbo,
	input  wire                      pause,
	input  wire zx_pkg::zx_machine_e machine,
	input  wire [4:0]                key_data,
	input  wire                      ear_in,
	input  wire [7:0]                ram_dout,
	output logic                     cpu_ce_p,
	output logic                     cpu_ce_n,
	output zx_pkg::zx_ram_req_t      ram_req,
	output logic [7:0]               cpu_din,
	output logic [2:0]               border_color,
	output logic                     ear_out,
	output logic                     mic_out,
	output logic                     page_scr
);

	logic                page_wr_stb;
	logic                ula_wr_stb;
	zx_pkg::zx_io_byte_u io_data;
	logic [7:0]          fe_read;

	zx_clock_enables i_clock_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.turbo    (turbo),
		.pause    (pause),
		.cpu_ce_p (cpu_ce_p),
		.cpu_ce_n (cpu_ce_n)
	);

	zx_port_decoder i_port_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.fe_read     (fe_read),
		.ram_dout    (ram_dout),
		.page_wr_stb (page_wr_stb),
		.ula_wr_stb  (ula_wr_stb),
		.io_data     (io_data),
		.cpu_din     (cpu_din)
	);

	zx_paging i_paging (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.machine     (machine),
		.bus         (bus),
		.page_wr_stb (page_wr_stb),
		.io_data     (io_data),
		.ram_req     (ram_req),
		.page_scr    (page_scr)
	);

	zx_ula_port i_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ula_wr_stb   (ula_wr_stb),
		.io_data      (io_data),
		.key_data     (key_data),
		.ear_in       (ear_in),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.fe_read      (fe_read)
	);

endmodule

`default_nettype wire

/* verification/zx_host_assert.sv */
// Concurrent checks on port write strobes, CPU clock enables and RAM writes
// Bound into the host top level

`timescale 1ns/1ps
`default_nettype none

module zx_host_assert (
	input wire                      clk_sys,
	input wire                      reset,
	input wire zx_pkg::zx_bus_t     bus,
	input wire zx_pkg::zx_ram_req_t ram_req,
	input wire                      page_wr_stb,
	input wire                      ula_wr_stb,
	input wire                      cpu_ce_p,
	input wire                      cpu_ce_n
);

	// Ports 0x7FFD and 0xFE never share a write
	strobes_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(page_wr_stb && ula_wr_stb))
		else $error("0x7FFD and ULA write strobes high in the same cycle");

	enables_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(cpu_ce_p && cpu_ce_n))
		else $error("cpu_ce_p and cpu_ce_n high in the same cycle");

	// ROM window is read only
	rom_no_write: assert property (@(posedge clk_sys) disable iff (reset)
		ram_req.we |-> (bus.addr[15:14] != 2'b00))
		else $error("RAM write enable set inside the ROM window");

endmodule

bind zx_host_top zx_host_assert i_host_assert (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.bus         (bus),
	.ram_req     (ram_req),
	.page_wr_stb (page_wr_stb),
	.ula_wr_stb  (ula_wr_stb),
	.cpu_ce_p    (cpu_ce_p),
	.cpu_ce_n    (cpu_ce_n)
);

`default_nettype wire

/* verification/tb_zx_host_top.sv */
// Testbench for the Spectrum 128 host glue
// Case-file driver, random ULA port reads, value checks and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_zx_host_top;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int HOLD_CYCLES  = 4;
	localparam int MAX_CASES    = 64;
	localparam int N_RANDOM     = 12;
	localparam int CE_SETTLE    = 40;
	localparam int CE_WINDOW    = 400;
	localparam int CASE_CYCLES  = 20;
	localparam int SLACK_CYCLES = 2000;

	localparam logic [3:0] OP_MEM_RD = 4'h0;
	localparam logic [3:0] OP_MEM_WR = 4'h1;
	localparam logic [3:0] OP_IO_WR  = 4'h2;
	localparam logic [3:0] OP_IO_RD  = 4'h3;
	localparam logic [3:0] OP_RATE   = 4'h4;
	localparam logic [3:0] OP_RESET  = 4'h5;
	localparam logic [3:0] OP_END    = 4'hF;

	logic                clk_sys;
	logic                reset;
	zx_pkg::zx_bus_t     bus;
	zx_pkg::zx_turbo_e   turbo;
	logic                pause;
	zx_pkg::zx_machine_e machine;
	logic [4:0]          key_data;
	logic                ear_in;
	logic [7:0]          ram_dout;
	logic                cpu_ce_p;
	logic                cpu_ce_n;
	zx_pkg::zx_ram_req_t ram_req;
	logic [7:0]          cpu_din;
	logic [2:0]          border_color;
	logic                ear_out;
	logic                mic_out;
	logic                page_scr;

	logic [31:0] case_mem [0:4*MAX_CASES-1];
	int          n_cases;
	int          n_rate_cases;
	logic        cases_loaded;
	logic [31:0] lcg_state;

	zx_host_top i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.turbo        (turbo),
		.pause        (pause),
		.machine      (machine),
		.key_data     (key_data),
		.ear_in       (ear_in),
		.ram_dout     (ram_dout),
		.cpu_ce_p     (cpu_ce_p),
		.cpu_ce_n     (cpu_ce_n),
		.ram_req      (ram_req),
		.cpu_din      (cpu_din),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.page_scr     (page_scr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected));
		end
	endtask

	// Paused rate must give no enables at all
	function automatic logic count_in_range(input int count, input int expected);
		if (expected == 0) begin
			return count == 0;
		end
		return (count + 1 >= expected) && (count <= expected + 1);
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic load_cases();
		int i;
		for (i = 0; i < 4 * MAX_CASES; i++) begin
			case_mem[i] = 'x;
		end
		$readmemh("verification/zx_host_cases.txt", case_mem);
		n_cases      = 0;
		n_rate_cases = 0;
		while (n_cases < MAX_CASES && case_mem[4*n_cases] !== 32'(OP_END)) begin
			if ($isunknown(case_mem[4*n_cases])) begin
				abort_run("Case file is missing or holds a malformed line");
			end
			if (case_mem[4*n_cases] == 32'(OP_RATE)) begin
				n_rate_cases++;
			end
			n_cases++;
		end
		if (n_cases == MAX_CASES) begin
			abort_run("Case file has no end marker");
		end
		cases_loaded = 1'b1;
	endtask

	// Bus back to idle for one cycle between accesses
	task automatic end_access();
		bus      = '0;
		ram_dout = 8'h00;
		@(negedge clk_sys);
	endtask

	// ========================================
	// Case operations
	// ========================================
	task automatic run_mem(input logic is_write, input logic [15:0] addr,
			input logic [7:0] data, input logic [31:0] expected);
		bus.addr = addr;
		bus.dout = data;
		bus.mreq = 1'b1;
		bus.rd   = ~is_write;
		bus.wr   = is_write;
		ram_dout = data;
		repeat (HOLD_CYCLES) @(negedge clk_sys);
		check_value($sformatf("ram_req.addr at 0x%04h", addr), ram_req.addr, expected[18:0]);
		check_value($sformatf("ram_req.we at 0x%04h", addr), ram_req.we, expected[19]);
		check_value($sformatf("ram_req.rd at 0x%04h", addr), ram_req.rd, !is_write);
		if (!is_write) begin
			check_value("cpu_din on memory read", cpu_din, data);
		end
		end_access();
	endtask

	task automatic run_io_write(input logic [15:0] addr, input logic [7:0] data,
			input logic [31:0] expected);
		bus.addr = addr;
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		repeat (HOLD_CYCLES) @(negedge clk_sys);
		check_value($sformatf("port state after write to 0x%04h", addr),
			{page_scr, ear_out, mic_out, border_color}, expected[5:0]);
		end_access();
	endtask

	// data holds ear_in in bit 5 and key_data below it
	task automatic run_io_read(input logic [15:0] addr, input logic [7:0] data,
			input logic [31:0] expected);
		bus.addr = addr;
		bus.iorq = 1'b1;
		bus.rd   = 1'b1;
		key_data = data[4:0];
		ear_in   = data[5];
		repeat (HOLD_CYCLES) @(negedge clk_sys);
		check_value($sformatf("cpu_din on read of port 0x%04h", addr), cpu_din, expected[7:0]);
		end_access();
	endtask

	task automatic run_rate(input logic [7:0] data, input logic [31:0] expected);
		int count_p;
		int count_n;
		turbo = zx_pkg::zx_turbo_e'(data[1:0]);
		pause = data[4];
		repeat (CE_SETTLE) @(negedge clk_sys);
		count_p = 0;
		count_n = 0;
		repeat (CE_WINDOW) begin
			@(negedge clk_sys);
			if (cpu_ce_p) begin
				count_p++;
			end
			if (cpu_ce_n) begin
				count_n++;
			end
		end
		check_value($sformatf("cpu_ce_p count %0d in %0d cycles, expected %0d +-1",
			count_p, CE_WINDOW, expected), count_in_range(count_p, expected), 1'b1);
		check_value($sformatf("cpu_ce_n count %0d in %0d cycles, expected %0d +-1",
			count_n, CE_WINDOW, expected), count_in_range(count_n, expected), 1'b1);
	endtask

	task automatic run_machine_reset(input logic [7:0] data, input logic [31:0] expected);
		machine = zx_pkg::zx_machine_e'(data[0]);
		reset   = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		check_value("outputs in reset",
			{cpu_ce_p, cpu_ce_n, ram_req.we, page_scr, ear_out, mic_out}, expected);
		reset = 1'b0;
		@(negedge clk_sys);
	endtask

	// ========================================
	// Watchdog
	// ========================================
	initial begin
		wait (cases_loaded);
		repeat ((n_cases + N_RANDOM) * CASE_CYCLES
				+ n_rate_cases * (CE_SETTLE + CE_WINDOW) + SLACK_CYCLES) begin
			@(posedge clk_sys);
		end
		abort_run("Watchdog expired, the run timed out");
	end

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int          idx;
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] expected;
		logic [31:0] rnd;

		reset        = 1'b1;
		bus          = '0;
		turbo        = zx_pkg::TURBO_3M5;
		pause        = 1'b0;
		machine      = zx_pkg::MACHINE_128K;
		key_data     = 5'h1F;
		ear_in       = 1'b0;
		ram_dout     = 8'h00;
		cases_loaded = 1'b0;
		lcg_state    = 32'd23511;

		load_cases();
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		for (idx = 0; idx < n_cases; idx++) begin
			op       = case_mem[4*idx][3:0];
			addr     = case_mem[4*idx+1][15:0];
			data     = case_mem[4*idx+2][7:0];
			expected = case_mem[4*idx+3];
			case (op)
				OP_MEM_RD: run_mem(1'b0, addr, data, expected);
				OP_MEM_WR: run_mem(1'b1, addr, data, expected);
				OP_IO_WR:  run_io_write(addr, data, expected);
				OP_IO_RD:  run_io_read(addr, data, expected);
				OP_RATE:   run_rate(data, expected);
				OP_RESET:  run_machine_reset(data, expected);
				default:   abort_run($sformatf("Case %0d has unknown operation %0h", idx, op));
			endcase
		end

		// Random port reads, odd ports float high
		for (idx = 0; idx < N_RANDOM; idx++) begin
			rnd      = lcg_next();
			addr     = rnd[31:16];
			data     = {2'b00, rnd[5:0]};
			expected = addr[0] ? 32'hFF : {24'd0, 1'b1, rnd[5], 1'b1, rnd[4:0]};
			run_io_read(addr, data, expected);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* zx_host_top.f */
rtl/zx_pkg.sv
rtl/zx_clock_enables.sv
rtl/zx_port_decoder.sv
rtl/zx_paging.sv
rtl/zx_ula_port.sv
rtl/zx_host_top.sv
verification/zx_host_assert.sv
verification/tb_zx_host_top.sv

/* verification/zx_host_cases.txt */
// Columns: op addr data expected, hex. op 0 mem read, 1 mem write, 2 I/O write, 3 I/O read, 4 rate, 5 reset, F end
// expected: {we, ram addr} | {page_scr, ear, mic, border} | cpu_din | ce_p per 400 cycles | 0
4 0000 00 32
4 0000 01 64
4 0000 02 C8
4 0000 12 00
0 C123 5A 00123
0 0010 A5 20010
0 4000 11 14000
0 8FFF 22 08FFF
2 00FE 15 15
2 7FFD 1B 35
0 C000 33 0C000
0 0100 44 24100
1 0200 55 24200
1 C010 66 8C010
1 4001 77 94001
2 00FE 0A 2A
3 00FF 00 FF
3 00FE 0A AA
3 12FE 25 E5
2 7FFD 26 0A
0 C000 00 18000
2 7FFD 0F 0A
0 C000 00 18000
0 0000 00 20000
5 0000 01 00
2 7FFD 1F 02
0 C000 00 00000
0 0000 00 24000
1 3FFF 00 27FFF
5 0000 00 00
2 7FFD 0C 22
0 FFFF 00 13FFF
F 0000 00 00
